/* design/uio_pkg.sv */
// I/O link package with opcodes, byte types, payload layouts and reply constants
`default_nettype none

package uio_pkg;

	// width of the byte position counter, saturates at its top value
	localparam int UIO_BYTE_CNT_W = 8;

	// one byte as it travels on SPI
	typedef logic [7:0] byte_t;
	// byte position inside a transfer
	typedef logic [UIO_BYTE_CNT_W-1:0] byte_cnt_t;

	// buttons byte as sent with opcode 01h
	typedef struct packed {
		logic       reserved;
		logic       no_csync;
		logic       ypbpr;
		logic       sd_disable;
		logic [1:0] switches;
		logic [1:0] buttons;
	} but_sw_t;

	// joystick word, lane 0 arrives first
	typedef logic [31:0] joy_t;
	// 64-bit core status word
	typedef logic [63:0] status_t;

	// command FSM states
	typedef enum logic [1:0] {
		IDLE,
		OPCODE,
		PAYLOAD,
		IGNORE
	} cmd_state_t;

	// first MISO byte of every transfer marks an 8-bit core
	localparam byte_t UIO_CORE_TYPE = 8'hA4;
	// feature bits reported after opcode 80h
	localparam logic [31:0] UIO_FEATURES = 32'h00C0_0012;

	// opcodes handled by this core
	localparam byte_t UIO_OP_BUT_SW   = 8'h01;
	localparam byte_t UIO_OP_KEY      = 8'h05;
	localparam byte_t UIO_OP_STATUS   = 8'h1E;
	localparam byte_t UIO_OP_JOY0     = 8'h60;
	localparam byte_t UIO_OP_JOY1     = 8'h61;
	localparam byte_t UIO_OP_FEATURES = 8'h80;

	// ps/2 scan-code prefixes
	localparam byte_t UIO_KEY_EXT   = 8'hE0;
	localparam byte_t UIO_KEY_BREAK = 8'hF0;

endpackage

`default_nettype wire

/* design/uio_byte_if.sv */
// byte hand-over between the SPI framer and the command FSM
`timescale 1ns/100ps
`default_nettype none

interface uio_byte_if;
	import uio_pkg::*;

	// one clk_sys pulse per completed MOSI byte
	logic rx_strobe;
	// assembled byte, valid while rx_strobe is high
	byte_t rx_byte;
	// position of rx_byte in the transfer with the opcode at 0
	byte_cnt_t byte_idx;
	// reply for the next byte on MISO
	byte_t tx_byte;

	// framer side produces bytes and takes the reply
	modport framer (
		output rx_strobe,
		output rx_byte,
		output byte_idx,
		input  tx_byte
	);

	// command side consumes bytes and picks the reply
	modport cmd (
		input  rx_strobe,
		input  rx_byte,
		input  byte_idx,
		output tx_byte
	);

endinterface

`default_nettype wire

/* design/spi_frame_counter.sv */
// SPI framer that oversamples the link, counts bits and bytes and drives MISO
`timescale 1ns/100ps
`default_nettype none

module spi_frame_counter (
	input  logic       clk_sys,
	input  logic       SPI_SS_IO,
	input  logic       spi_clk_i,
	input  logic       spi_mosi_i,
	output logic       spi_miso_o,
	uio_byte_if.framer bus
);
	import uio_pkg::*;

	// sck sync stages 0 and 1, stage 2 is the history for edge detect
	logic [2:0] sck_q;
	// mosi runs through the same two stages so it lines up with sck_q[1]
	logic [1:0] mosi_q;
	logic       sck_rise;
	logic       sck_fall;
	logic [2:0] bit_cnt;
	byte_cnt_t  byte_cnt;
	// first seven bits of the byte in flight
	logic [6:0] rx_shift;
	// reply shifter, msb goes out first
	byte_t      tx_shift;

	assign sck_rise = sck_q[1] & ~sck_q[2];
	assign sck_fall = ~sck_q[1] & sck_q[2];

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			sck_q <= '0;
		end else begin
			sck_q <= {sck_q[1:0], spi_clk_i};
		end
	end

	always_ff @(posedge clk_sys) begin
		mosi_q <= {mosi_q[0], spi_mosi_i};
	end

	// bit and byte counting, strobe on the eighth rising edge
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bit_cnt <= '0;
			byte_cnt <= '0;
			bus.rx_strobe <= 1'b0;
		end else begin
			bus.rx_strobe <= sck_rise && (bit_cnt == 3'd7);
			if (sck_rise) begin
				bit_cnt <= bit_cnt + 3'd1;
				// byte counter sticks at its top value on long transfers
				if ((bit_cnt == 3'd7) && !(&byte_cnt)) begin
					byte_cnt <= byte_cnt + byte_cnt_t'(1);
				end
			end
		end
	end

	// mosi assembly, a cut-off byte never reaches rx_byte since bit_cnt restarts
	always_ff @(posedge clk_sys) begin
		if (sck_rise) begin
			rx_shift <= {rx_shift[5:0], mosi_q[1]};
			if (bit_cnt == 3'd7) begin
				bus.rx_byte <= {rx_shift, mosi_q[1]};
				bus.byte_idx <= byte_cnt;
			end
		end
	end

	// core type sits in the shifter while deselected so bit 7 is out early
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			tx_shift <= UIO_CORE_TYPE;
		end else if (sck_fall) begin
			// wrapped bit counter means a new byte starts here
			if (bit_cnt == 3'd0) begin
				tx_shift <= bus.tx_byte;
			end else begin
				tx_shift <= {tx_shift[6:0], 1'b0};
			end
		end
	end

	assign spi_miso_o = tx_shift[7];

	// a deselected link never hands a byte to the command side
	a_no_strobe_in_ss: assert property (@(posedge clk_sys) SPI_SS_IO |-> !bus.rx_strobe);

endmodule

`default_nettype wire

/* design/uio_cmd_fsm.sv */
// command FSM that latches the opcode, routes payload bytes and picks reply bytes
`timescale 1ns/100ps
`default_nettype none

module uio_cmd_fsm (
	input  logic               clk_sys,
	input  logic               SPI_SS_IO,
	uio_byte_if.cmd            bus,
	output logic               but_sw_we_o,
	output logic               joy0_we_o,
	output logic               joy1_we_o,
	output logic               status_we_o,
	output uio_pkg::byte_cnt_t lane_o,
	output uio_pkg::byte_t     data_o,
	output logic               key_we_o,
	output logic               key_first_o
);
	import uio_pkg::*;

	cmd_state_t state;
	byte_t      opcode;
	logic       known_op;
	logic       payload_stb;
	byte_t      reply_next;

	// opcodes this core answers, everything else is skipped
	always_comb begin
		case (bus.rx_byte)
			UIO_OP_BUT_SW, UIO_OP_KEY, UIO_OP_STATUS,
			UIO_OP_JOY0, UIO_OP_JOY1, UIO_OP_FEATURES:
				known_op = 1'b1;
			default:
				known_op = 1'b0;
		endcase
	end

	// SS high restarts every transfer in IDLE
	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			state <= IDLE;
		end else if (bus.rx_strobe) begin
			case (state)
				IDLE:    state <= known_op ? OPCODE : IGNORE;
				OPCODE:  state <= PAYLOAD;
				default: state <= state;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (bus.rx_strobe && (bus.byte_idx == '0)) begin
			opcode <= bus.rx_byte;
		end
	end

	// one write enable per target straight from the strobe
	assign payload_stb = bus.rx_strobe && ((state == OPCODE) || (state == PAYLOAD));
	assign but_sw_we_o = payload_stb && (opcode == UIO_OP_BUT_SW);
	assign joy0_we_o   = payload_stb && (opcode == UIO_OP_JOY0);
	assign joy1_we_o   = payload_stb && (opcode == UIO_OP_JOY1);
	assign status_we_o = payload_stb && (opcode == UIO_OP_STATUS);
	assign key_we_o    = payload_stb && (opcode == UIO_OP_KEY);
	// still in OPCODE means this is the first payload byte
	assign key_first_o = (state == OPCODE);
	// payload lane 0 is the byte after the opcode
	assign lane_o = bus.byte_idx - byte_cnt_t'(1);
	assign data_o = bus.rx_byte;

	// reply for the byte after the one just received
	always_comb begin
		reply_next = '0;
		if (bus.byte_idx == '0) begin
			// echo the feature opcode to confirm support
			if (bus.rx_byte == UIO_OP_FEATURES) begin
				reply_next = UIO_OP_FEATURES;
			end
		end else if ((opcode == UIO_OP_FEATURES) && (bus.byte_idx <= byte_cnt_t'(4))) begin
			reply_next = UIO_FEATURES[(4 - bus.byte_idx) * 8 +: 8];
		end
	end

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			bus.tx_byte <= '0;
		end else if (bus.rx_strobe) begin
			bus.tx_byte <= reply_next;
		end
	end

	// targets in the field registers and key decoder never see two writes at once
	a_one_target: assert property (@(posedge clk_sys)
		$onehot0({but_sw_we_o, joy0_we_o, joy1_we_o, status_we_o, key_we_o}));

endmodule

`default_nettype wire

/* design/uio_field_reg.sv */
// byte-lane register filled little-endian from command payload bytes
`timescale 1ns/100ps
`default_nettype none

module uio_field_reg #(
	parameter type payload_t = uio_pkg::but_sw_t
) (
	input  logic               clk_sys,
	input  logic               wr_en_i,
	input  uio_pkg::byte_cnt_t lane_i,
	input  uio_pkg::byte_t     data_i,
	output payload_t           value_o
);

	// number of whole byte lanes in the payload
	localparam int LANES = $bits(payload_t) / 8;

	logic [$bits(payload_t)-1:0] value_q;

	// extra bytes past the payload width fall away here
	always_ff @(posedge clk_sys) begin
		if (wr_en_i && (lane_i < LANES)) begin
			value_q[lane_i * 8 +: 8] <= data_i;
		end
	end

	// fields keep their value across transfers
	assign value_o = payload_t'(value_q);

	// write enable comes out of the reset FSM and must always be known
	a_we_known: assert property (@(posedge clk_sys) !$isunknown(wr_en_i));

endmodule

`default_nettype wire

/* design/uio_key_decoder.sv */
// PS/2 scan-code decoder producing key events with make/break and extended flags
`timescale 1ns/100ps
`default_nettype none

module uio_key_decoder (
	input  logic           clk_sys,
	input  logic           SPI_SS_IO,
	input  logic           key_we_i,
	input  logic           key_first_i,
	input  uio_pkg::byte_t data_i,
	output logic           key_strobe_o,
	output uio_pkg::byte_t key_code_o,
	output logic           key_pressed_o,
	output logic           key_extended_o
);
	import uio_pkg::*;

	// prefixes seen so far for the pending key
	logic ext_q;
	logic brk_q;
	// flags as they apply to the current byte
	logic ext_cur;
	logic brk_cur;
	logic is_prefix;

	// first payload byte of a transfer starts a fresh sequence
	assign ext_cur   = ext_q & ~key_first_i;
	assign brk_cur   = brk_q & ~key_first_i;
	assign is_prefix = (data_i == UIO_KEY_EXT) || (data_i == UIO_KEY_BREAK);

	always_ff @(posedge clk_sys or posedge SPI_SS_IO) begin
		if (SPI_SS_IO) begin
			ext_q <= 1'b0;
			brk_q <= 1'b0;
			key_strobe_o <= 1'b0;
		end else begin
			key_strobe_o <= 1'b0;
			if (key_we_i) begin
				if (data_i == UIO_KEY_EXT) begin
					ext_q <= 1'b1;
					brk_q <= brk_cur;
				end else if (data_i == UIO_KEY_BREAK) begin
					ext_q <= ext_cur;
					brk_q <= 1'b1;
				end else begin
					// key code ends the sequence
					ext_q <= 1'b0;
					brk_q <= 1'b0;
					key_strobe_o <= 1'b1;
				end
			end
		end
	end

	// event payload, valid from the key_strobe_o cycle on
	always_ff @(posedge clk_sys) begin
		if (key_we_i && !is_prefix) begin
			key_code_o <= data_i;
			key_pressed_o <= ~brk_cur;
			key_extended_o <= ext_cur;
		end
	end

endmodule

`default_nettype wire

/* design/user_io_top.sv */
// I/O link top that turns controller SPI commands into core-facing registers
`timescale 1ns/100ps
`default_nettype none

module user_io_top (
	input  logic             clk_sys,
	input  logic             SPI_SS_IO,
	input  logic             SPI_CLK,
	input  logic             SPI_MOSI,
	output logic             SPI_MISO,
	output logic [1:0]       buttons_o,
	output logic [1:0]       switches_o,
	output logic             scandoubler_disable_o,
	output logic             ypbpr_o,
	output logic             no_csync_o,
	output uio_pkg::joy_t    joystick_0_o,
	output uio_pkg::joy_t    joystick_1_o,
	output uio_pkg::status_t status_o,
	output logic             key_strobe_o,
	output uio_pkg::byte_t   key_code_o,
	output logic             key_pressed_o,
	output logic             key_extended_o
);
	import uio_pkg::*;

	// framer to FSM byte channel
	uio_byte_if byte_bus ();

	// per-target write enables with shared lane and data
	logic      but_sw_we;
	logic      joy0_we;
	logic      joy1_we;
	logic      status_we;
	logic      key_we;
	logic      key_first;
	byte_cnt_t lane;
	byte_t     wr_data;
	but_sw_t   but_sw;

	spi_frame_counter u_framer (
		.clk_sys    (clk_sys),
		.SPI_SS_IO  (SPI_SS_IO),
		.spi_clk_i  (SPI_CLK),
		.spi_mosi_i (SPI_MOSI),
		.spi_miso_o (SPI_MISO),
		.bus        (byte_bus.framer)
	);

	uio_cmd_fsm u_cmd (
		.clk_sys     (clk_sys),
		.SPI_SS_IO   (SPI_SS_IO),
		.bus         (byte_bus.cmd),
		.but_sw_we_o (but_sw_we),
		.joy0_we_o   (joy0_we),
		.joy1_we_o   (joy1_we),
		.status_we_o (status_we),
		.lane_o      (lane),
		.data_o      (wr_data),
		.key_we_o    (key_we),
		.key_first_o (key_first)
	);

	// one register per target, sized by its payload type
	uio_field_reg #(.payload_t(but_sw_t)) u_but_sw (
		.clk_sys (clk_sys),
		.wr_en_i (but_sw_we),
		.lane_i  (lane),
		.data_i  (wr_data),
		.value_o (but_sw)
	);

	uio_field_reg #(.payload_t(joy_t)) u_joy0 (
		.clk_sys (clk_sys),
		.wr_en_i (joy0_we),
		.lane_i  (lane),
		.data_i  (wr_data),
		.value_o (joystick_0_o)
	);

	uio_field_reg #(.payload_t(joy_t)) u_joy1 (
		.clk_sys (clk_sys),
		.wr_en_i (joy1_we),
		.lane_i  (lane),
		.data_i  (wr_data),
		.value_o (joystick_1_o)
	);

	uio_field_reg #(.payload_t(status_t)) u_status (
		.clk_sys (clk_sys),
		.wr_en_i (status_we),
		.lane_i  (lane),
		.data_i  (wr_data),
		.value_o (status_o)
	);

	uio_key_decoder u_keys (
		.clk_sys        (clk_sys),
		.SPI_SS_IO      (SPI_SS_IO),
		.key_we_i       (key_we),
		.key_first_i    (key_first),
		.data_i         (wr_data),
		.key_strobe_o   (key_strobe_o),
		.key_code_o     (key_code_o),
		.key_pressed_o  (key_pressed_o),
		.key_extended_o (key_extended_o)
	);

	// buttons byte unpacked onto the core pins
	assign buttons_o             = but_sw.buttons;
	assign switches_o            = but_sw.switches;
	assign scandoubler_disable_o = but_sw.sd_disable;
	assign ypbpr_o               = but_sw.ypbpr;
	assign no_csync_o            = but_sw.no_csync;

endmodule

`default_nettype wire

/* sim/uio_checker.sv */
// scoreboard that compares DUT ports and MISO bytes with the expected values of each test
`timescale 1ns/100ps
`default_nettype none

module uio_checker #(
	parameter int MAX_BYTES = 16
) (
	input  logic                   clk_sys,
	input  logic                   check_i,
	input  logic                   report_i,
	input  int                     test_num_i,
	input  int                     n_bytes_i,
	input  logic [4:0]             mask_i,
	input  logic [MAX_BYTES*8-1:0] miso_got_i,
	input  logic [MAX_BYTES*8-1:0] miso_exp_i,
	input  logic [6:0]             exp_but_sw_i,
	input  uio_pkg::joy_t          exp_joy0_i,
	input  uio_pkg::joy_t          exp_joy1_i,
	input  uio_pkg::status_t       exp_status_i,
	input  int                     exp_key_cnt_i,
	input  uio_pkg::byte_t         exp_key_code_i,
	input  logic                   exp_key_pressed_i,
	input  logic                   exp_key_ext_i,
	input  logic [1:0]             buttons_i,
	input  logic [1:0]             switches_i,
	input  logic                   scandoubler_disable_i,
	input  logic                   ypbpr_i,
	input  logic                   no_csync_i,
	input  uio_pkg::joy_t          joystick_0_i,
	input  uio_pkg::joy_t          joystick_1_i,
	input  uio_pkg::status_t       status_i,
	input  logic                   key_strobe_i,
	input  uio_pkg::byte_t         key_code_i,
	input  logic                   key_pressed_i,
	input  logic                   key_extended_i,
	output int                     errors_o
);

	int tests_run;
	int test_errs;
	// key_strobe pulses seen since the last check
	int key_events;
	int i;

	initial begin
		tests_run = 0;
		test_errs = 0;
		key_events = 0;
		errors_o = 0;
	end

	task automatic compare_value(
		input string       name,
		input logic [63:0] expected,
		input logic [63:0] actual
	);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s expected %0h got %0h", $time, name, expected, actual);
			test_errs++;
		end
	endtask

	always @(posedge clk_sys) begin
		if (key_strobe_i) begin
			key_events++;
		end
		if (check_i) begin
			test_errs = 0;
			// core type first, then the replies
			for (i = 0; i < n_bytes_i; i++) begin
				compare_value($sformatf("SPI_MISO byte %0d", i),
					64'(miso_exp_i[i*8 +: 8]), 64'(miso_got_i[i*8 +: 8]));
			end
			// mask bits pick the fields that hold known values by now
			if (mask_i[0]) begin
				compare_value("buttons_o", 64'(exp_but_sw_i[1:0]), 64'(buttons_i));
				compare_value("switches_o", 64'(exp_but_sw_i[3:2]), 64'(switches_i));
				compare_value("scandoubler_disable_o", 64'(exp_but_sw_i[4]),
					64'(scandoubler_disable_i));
				compare_value("ypbpr_o", 64'(exp_but_sw_i[5]), 64'(ypbpr_i));
				compare_value("no_csync_o", 64'(exp_but_sw_i[6]), 64'(no_csync_i));
			end
			if (mask_i[1]) begin
				compare_value("joystick_0_o", 64'(exp_joy0_i), 64'(joystick_0_i));
			end
			if (mask_i[2]) begin
				compare_value("joystick_1_o", 64'(exp_joy1_i), 64'(joystick_1_i));
			end
			if (mask_i[3]) begin
				compare_value("status_o", exp_status_i, status_i);
			end
			compare_value("key_strobe_o count", 64'(exp_key_cnt_i), 64'(key_events));
			if (mask_i[4]) begin
				compare_value("key_code_o", 64'(exp_key_code_i), 64'(key_code_i));
				compare_value("key_pressed_o", 64'(exp_key_pressed_i), 64'(key_pressed_i));
				compare_value("key_extended_o", 64'(exp_key_ext_i), 64'(key_extended_i));
			end
			if (test_errs == 0) begin
				$display("test %0d passed", test_num_i);
			end else begin
				$display("test %0d failed with %0d mismatches", test_num_i, test_errs);
			end
			errors_o = errors_o + test_errs;
			tests_run++;
			key_events = 0;
		end
		if (report_i) begin
			$display("%0d tests checked, %0d mismatches in total", tests_run, errors_o);
		end
	end

endmodule

`default_nettype wire

/* sim/user_io_tb.sv */
// testbench for the I/O link that replays SPI transfers listed in the tests file
`timescale 1ns/100ps
`default_nettype none

module user_io_tb;
	import uio_pkg::*;

	// four clk_sys cycles per SPI half period, so one bit takes eight
	localparam int HALF_BIT    = 4;
	localparam int BYTE_CYCLES = 8 * 8;
	// room per test for SS framing, the check pulse and the idle gap
	localparam int TEST_MARGIN = 200;
	localparam int MAX_BYTES   = 16;
	localparam int MEM_WORDS   = 512;

	logic       clk_sys;
	logic       SPI_SS_IO;
	logic       SPI_CLK;
	logic       SPI_MOSI;
	logic       SPI_MISO;
	logic [1:0] buttons_o;
	logic [1:0] switches_o;
	logic       scandoubler_disable_o;
	logic       ypbpr_o;
	logic       no_csync_o;
	joy_t       joystick_0_o;
	joy_t       joystick_1_o;
	status_t    status_o;
	logic       key_strobe_o;
	byte_t      key_code_o;
	logic       key_pressed_o;
	logic       key_extended_o;

	// whole tests file, one hex word per entry
	logic [63:0] tests_mem [MEM_WORDS];
	byte_t       mosi_bytes [MAX_BYTES];
	// MISO bytes as the controller saw them, byte 0 in the low lane
	logic [MAX_BYTES*8-1:0] miso_got;
	logic [MAX_BYTES*8-1:0] miso_exp;

	// hand-over to the checker
	logic       check;
	logic       report;
	int         test_num;
	int         n_bytes;
	logic [4:0] mask;
	logic [6:0] exp_but_sw;
	joy_t       exp_joy0;
	joy_t       exp_joy1;
	status_t    exp_status;
	int         exp_key_cnt;
	byte_t      exp_key_code;
	logic       exp_key_pressed;
	logic       exp_key_ext;
	int         err_count;

	int seed;
	int n_tests;
	int total_bytes;
	int limit;
	int cycle_cnt;

	user_io_top u_dut (.*);

	uio_checker #(.MAX_BYTES(MAX_BYTES)) u_chk (
		.clk_sys               (clk_sys),
		.check_i               (check),
		.report_i              (report),
		.test_num_i            (test_num),
		.n_bytes_i             (n_bytes),
		.mask_i                (mask),
		.miso_got_i            (miso_got),
		.miso_exp_i            (miso_exp),
		.exp_but_sw_i          (exp_but_sw),
		.exp_joy0_i            (exp_joy0),
		.exp_joy1_i            (exp_joy1),
		.exp_status_i          (exp_status),
		.exp_key_cnt_i         (exp_key_cnt),
		.exp_key_code_i        (exp_key_code),
		.exp_key_pressed_i     (exp_key_pressed),
		.exp_key_ext_i         (exp_key_ext),
		.buttons_i             (buttons_o),
		.switches_i            (switches_o),
		.scandoubler_disable_i (scandoubler_disable_o),
		.ypbpr_i               (ypbpr_o),
		.no_csync_i            (no_csync_o),
		.joystick_0_i          (joystick_0_o),
		.joystick_1_i          (joystick_1_o),
		.status_i              (status_o),
		.key_strobe_i          (key_strobe_o),
		.key_code_i            (key_code_o),
		.key_pressed_i         (key_pressed_o),
		.key_extended_i        (key_extended_o),
		.errors_o              (err_count)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	// walks the file once to size the run, a zero byte count ends the list
	task automatic count_tests();
		int ptr;
		int n;
		ptr = 0;
		n_tests = 0;
		total_bytes = 0;
		while ((ptr < MEM_WORDS) && (tests_mem[ptr] != 64'd0)) begin
			n = int'(tests_mem[ptr]);
			total_bytes += n;
			n_tests++;
			ptr += 3 + 2 * n + 8;
		end
	endtask

	// mode 0 bits, msb first, MOSI moves with the falling SPI_CLK edge
	task automatic shift_bits(input byte_t value, input int nbits, output byte_t miso_in);
		int b;
		miso_in = '0;
		for (b = 7; b > 7 - nbits; b--) begin
			SPI_MOSI = value[b];
			repeat (HALF_BIT) @(negedge clk_sys);
			// MISO settled three cycles after the last fall
			miso_in[b] = SPI_MISO;
			SPI_CLK = 1'b1;
			repeat (HALF_BIT) @(negedge clk_sys);
			SPI_CLK = 1'b0;
		end
	endtask

	// full bytes first, then an optional cut-off byte of ones
	task automatic run_transfer(input int nbytes, input int cut_bits);
		int i;
		byte_t rx;
		miso_got = '0;
		SPI_SS_IO = 1'b0;
		repeat (HALF_BIT) @(negedge clk_sys);
		for (i = 0; i < nbytes; i++) begin
			shift_bits(mosi_bytes[i], 8, rx);
			miso_got[i*8 +: 8] = rx;
		end
		if (cut_bits > 0) begin
			shift_bits(8'hFF, cut_bits, rx);
		end
		repeat (HALF_BIT) @(negedge clk_sys);
		SPI_SS_IO = 1'b1;
	endtask

	// run limit from the length of all transfers
	initial begin
		cycle_cnt = 0;
		wait (limit > 0);
		while (cycle_cnt < limit) begin
			@(posedge clk_sys);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the transfers did not finish", cycle_cnt);
		$display("Errors found");
		$finish;
	end

	initial begin
		int t;
		int i;
		int ptr;
		int base;
		int cut;
		int gap;
		SPI_SS_IO = 1'b1;
		SPI_CLK = 1'b0;
		SPI_MOSI = 1'b0;
		check = 1'b0;
		report = 1'b0;
		test_num = 0;
		n_bytes = 0;
		mask = '0;
		miso_got = '0;
		miso_exp = '0;
		exp_but_sw = '0;
		exp_joy0 = '0;
		exp_joy1 = '0;
		exp_status = '0;
		exp_key_cnt = 0;
		exp_key_code = '0;
		exp_key_pressed = 1'b0;
		exp_key_ext = 1'b0;
		limit = 0;
		seed = 58866;
		$readmemh("sim/uio_tests.mem", tests_mem);
		count_tests();
		limit = total_bytes * BYTE_CYCLES + n_tests * TEST_MARGIN;
		// link deselected for five cycles acts as reset
		repeat (5) @(posedge clk_sys);
		@(negedge clk_sys);
		if (n_tests == 0) begin
			$display("no test could be read from sim/uio_tests.mem");
			$display("Errors found");
		end else begin
			ptr = 0;
			for (t = 0; t < n_tests; t++) begin
				n_bytes = int'(tests_mem[ptr]);
				cut = int'(tests_mem[ptr + 1]);
				for (i = 0; i < n_bytes; i++) begin
					mosi_bytes[i] = tests_mem[ptr + 3 + i][7:0];
				end
				run_transfer(n_bytes, cut);
				// expected values follow once SS is high again
				mask = tests_mem[ptr + 2][4:0];
				base = ptr + 3 + n_bytes;
				miso_exp = '0;
				for (i = 0; i < n_bytes; i++) begin
					miso_exp[i*8 +: 8] = tests_mem[base + i][7:0];
				end
				base = base + n_bytes;
				exp_but_sw = tests_mem[base][6:0];
				exp_joy0 = tests_mem[base + 1][31:0];
				exp_joy1 = tests_mem[base + 2][31:0];
				exp_status = tests_mem[base + 3];
				exp_key_cnt = int'(tests_mem[base + 4]);
				exp_key_code = tests_mem[base + 5][7:0];
				exp_key_pressed = tests_mem[base + 6][0];
				exp_key_ext = tests_mem[base + 7][0];
				ptr = base + 8;
				test_num = t + 1;
				check = 1'b1;
				@(negedge clk_sys);
				check = 1'b0;
				// idle gap of 4 to 11 cycles
				gap = 4 + int'($unsigned($random(seed)) % 8);
				repeat (gap) @(negedge clk_sys);
			end
			report = 1'b1;
			@(negedge clk_sys);
			report = 1'b0;
			if (err_count == 0) begin
				$display("No errors");
			end else begin
				$display("Errors found");
			end
		end
		$finish;
	end

endmodule

`default_nettype wire

/* sim/uio_tests.mem */
// per test: byte count, cut-off bits, check mask, MOSI bytes, expected MISO bytes,
// then but_sw, joy0, joy1, status, key strobes, key code, pressed, extended
2 0 01  01 5B
A4 00  5B 0 0 0 0 0 0 0
5 0 03  60 11 22 33 44
A4 00 00 00 00  5B 44332211 0 0 0 0 0 0
7 0 07  61 55 66 77 88 99 AA
A4 00 00 00 00 00 00  5B 44332211 88776655 0 0 0 0 0
9 0 0F  1E 01 02 03 04 05 06 07 08
A4 00 00 00 00 00 00 00 00  5B 44332211 88776655 0807060504030201 0 0 0 0
4 0 0F  1E A1 B2 C3
A4 00 00 00  5B 44332211 88776655 0807060504C3B2A1 0 0 0 0
4 0 1F  05 E0 F0 1C
A4 00 00 00  5B 44332211 88776655 0807060504C3B2A1 1 1C 0 1
2 0 1F  05 1C
A4 00  5B 44332211 88776655 0807060504C3B2A1 1 1C 1 0
6 0 1F  80 00 00 00 00 00
A4 80 00 C0 00 12  5B 44332211 88776655 0807060504C3B2A1 0 1C 1 0
1 4 1F  01
A4  5B 44332211 88776655 0807060504C3B2A1 0 1C 1 0
3 0 1F  33 5A 5A
A4 00 00  5B 44332211 88776655 0807060504C3B2A1 0 1C 1 0
2 0 1F  01 24
A4 00  24 44332211 88776655 0807060504C3B2A1 0 1C 1 0
0

/* sources.f */
design/uio_pkg.sv
design/uio_byte_if.sv
design/spi_frame_counter.sv
design/uio_cmd_fsm.sv
design/uio_field_reg.sv
design/uio_key_decoder.sv
design/user_io_top.sv
sim/uio_checker.sv
sim/user_io_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= user_io_tb
VFLAGS    ?= --binary --timing --assert -Wno-fatal
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run and look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR, TOP, VFLAGS, OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f sources.f
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(OBJ_DIR)
